// ==== list.f ====
+incdir+.
rvIsaPkg.sv
pipeCtrlPkg.sv
instrDecode.sv
operandFetch.sv
regBank.sv
frontEnd.sv
tbChecks.sv
tbFrontEnd.sv

// ==== Bender.yml ====
package:
  name: frontEnd

export_include_dirs:
  - .

sources:
  - files:
      - rvIsaPkg.sv
      - pipeCtrlPkg.sv
      - instrDecode.sv
      - operandFetch.sv
      - regBank.sv
      - frontEnd.sv
  - target: test
    files:
      - tbChecks.sv
      - tbFrontEnd.sv

// ==== tbFrontEnd.sv ====
// Front end testbench with an RV32I program, write-back agent, watchdog and closing report
`include "frontEnd_macros.svh"

module tbFrontEnd;
    timeunit 1ns;
    timeprecision 100ps;
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    localparam int CLK_PERIOD       = 100;
    localparam int CYCLES_PER_INSTR = 40;               // Watchdog budget per program word

    logic              clk;
    logic              reset;
    instrWord          instruction;
    logic [`XLEN-1:0]  npc, npcNext;
    logic [`TAG_W-1:0] tagIn, tagNext;
    logic              wbEn;
    logic [`XLEN-1:0]  wbData;
    logic [`XLEN-1:0]  opA, opB, opC, npcOut;
    opCode             opOut;
    xuSel              xuOut;
    logic [`TAG_W-1:0] tagOut;
    logic              issue;
    logic [`NREGS-1:1] wrAddr;
    logic [`XLEN-1:0]  shadow [`NREGS];                 // What execute wrote back
    int                operandErrs, controlErrs;
    int                stallCycles = 0;
    int                seed = 32'h4b9f_9a55;
    int                runLimit = 0;
    logic [31:0]       progWords [$];

    frontEnd UUT (
        .clk, .reset, .instruction, .npc, .tagIn, .wbEn, .wbData,
        .opA, .opB, .opC, .npcOut, .opOut, .xuOut, .tagOut, .issue, .wrAddr
    );

    tbChecks checks (
        .clk, .reset, .instruction, .npc, .tagIn, .wbEn, .shadow,
        .opA, .opB, .opC, .npcOut, .opOut, .xuOut, .tagOut, .issue, .wrAddr,
        .operandErrs, .controlErrs
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Write-back agent, wbEn stays high so the queue tail shows on wrAddr
    always @(posedge clk) begin
        #10;
        wbData = $random(seed);                         // Fresh data every cycle
    end

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < `NREGS; r++) begin
                shadow[r] <= '0;
            end
        end else begin
            for (int r = 1; r < `NREGS; r++) begin
                if (wrAddr[r]) begin
                    shadow[r] <= wbData;
                end
            end
        end
    end

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic buildProgram();
        for (int r = 1; r <= 12; r++) begin
            progWords.push_back(encI(12'(r), 5'd0, 3'b000, 5'(r), OP_IMM));   // Independent stream
        end
        progWords.push_back(encI(12'hffb, 5'd2, 3'b000, 5'd16, OP_IMM));      // ADDI, negative
        progWords.push_back(encI(12'h7ff, 5'd3, 3'b111, 5'd17, OP_IMM));      // ANDI, positive
        progWords.push_back(encS(12'hff8, 5'd4, 5'd5, 3'b010));               // SW -8
        progWords.push_back(encS(12'h100, 5'd6, 5'd7, 3'b001));               // SH +256
        progWords.push_back(encB(13'h1ff0, 5'd8, 5'd9, 3'b000));              // BEQ -16
        progWords.push_back(encB(13'h07fe, 5'd10, 5'd11, 3'b001));            // BNE +2046
        progWords.push_back({20'h80000, 5'd18, OP_LUI});
        progWords.push_back({20'h12345, 5'd19, OP_AUIPC});
        progWords.push_back(encJ(21'h1ff800, 5'd24));                         // JAL -2048
        progWords.push_back(encJ(21'h0ffffe, 5'd25));                         // JAL far forward
        progWords.push_back(encR(7'b0100000, 5'd12, 5'd1, 3'b000, 5'd26));    // SUB
        progWords.push_back(32'h0000_0000);                                   // Unknown, NOP
        progWords.push_back(encI(12'h800, 5'd3, 3'b000, 5'd27, OP_JALR));
        progWords.push_back(encI(12'h001, 5'd0, 3'b000, 5'd20, OP_IMM));      // RAW producer
        progWords.push_back(encR(7'b0000000, 5'd20, 5'd20, 3'b000, 5'd21));   // Consumer stalls
        progWords.push_back(encS(12'h000, 5'd5, 5'd6, 3'b010));               // SW pending
        progWords.push_back(encI(12'h004, 5'd7, 3'b010, 5'd22, OP_LOAD));     // LW waits on SW
        progWords.push_back(encI(12'h010, 5'd8, 3'b100, 5'd23, OP_LOAD));     // LBU, no store
        progWords.push_back(encS(12'h00c, 5'd9, 5'd10, 3'b000));              // SB
        progWords.push_back(encI(12'h020, 5'd11, 3'b101, 5'd28, OP_LOAD));    // LHU waits on SB
        for (int n = 0; n < 3; n++) begin
            progWords.push_back(32'h0000_0000);         // Drain the queue
        end
    endtask

    // Present one word at edge plus 10 ns, hold it until issue is seen mid-cycle
    task automatic sendInstr(input logic [31:0] word);
        logic issued;
        instruction.raw = word;
        npc   = npcNext;
        tagIn = tagNext;
        do begin
            #(CLK_PERIOD / 2 - 10);
            issued = issue;
            if (!issued) begin
                stallCycles++;
            end
            @(posedge clk);
            #10;
        end while (!issued);
        npcNext = npcNext + 32'd4;
        tagNext = tagNext + 1'b1;
    endtask

    initial begin
        reset           = 1'b0;
        instruction.raw = '0;
        npc             = '0;
        tagIn           = '0;
        wbEn            = 1'b0;
        wbData          = '0;
        npcNext         = 32'h0000_1000;
        tagNext         = 4'd1;
        buildProgram();
        runLimit = progWords.size() * CYCLES_PER_INSTR * CLK_PERIOD;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b1;
        wbEn  = 1'b1;
        @(posedge clk);                                 // One idle cycle in the reset state
        #10;
        foreach (progWords[i]) begin
            sendInstr(progWords[i]);
        end
        repeat (`LOCK_DEPTH + 2) @(posedge clk);
        if (stallCycles == 0) begin
            $display("No stall was reached, so the hazard checks were never exercised");
        end
        $display("Errors: operand %0d, control %0d, stall cycles seen %0d",
                 operandErrs, controlErrs, stallCycles);
        if (operandErrs == 0 && controlErrs == 0 && stallCycles > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (runLimit > 0);
        #(runLimit);
        $display("Timeout: the program did not finish within %0d ns", runLimit);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== tbChecks.sv ====
// Front end reference model predicting issue, retirement and operands, checked by assertions
`include "frontEnd_macros.svh"

module tbChecks (
    input  logic                clk,
    input  logic                reset,
    input  rvIsaPkg::instrWord  instruction,
    input  logic [`XLEN-1:0]    npc,
    input  logic [`TAG_W-1:0]   tagIn,
    input  logic                wbEn,
    input  logic [`XLEN-1:0]    shadow [`NREGS],    // Register values as written back
    input  logic [`XLEN-1:0]    opA,
    input  logic [`XLEN-1:0]    opB,
    input  logic [`XLEN-1:0]    opC,
    input  logic [`XLEN-1:0]    npcOut,
    input  pipeCtrlPkg::opCode  opOut,
    input  pipeCtrlPkg::xuSel   xuOut,
    input  logic [`TAG_W-1:0]   tagOut,
    input  logic                issue,
    input  logic [`NREGS-1:1]   wrAddr,
    output int                  operandErrs,
    output int                  controlErrs
);
    timeunit 1ns;
    timeprecision 100ps;
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    instrFmt           mFmt;
    logic              useRs1, useRs2, useRd, load, store;
    logic [4:0]        s1, s2, d;
    logic [`XLEN-1:0]  mImm, regA, regB, rA, rB, rC;
    logic [`NREGS-1:0] mQueue [`LOCK_DEPTH];            // Model of pending writes
    logic [`NREGS-1:0] mLocked, pushMask;
    logic              mIssue;
    logic [`XLEN-1:0]  eA, eB, eC, eNpc;                // Expected issue registers
    logic [`TAG_W-1:0] eTag;
    logic              eBubble;

    initial begin
        operandErrs = 0;
        controlErrs = 0;
    end

    assign s1 = instruction.r.rs1;
    assign s2 = instruction.r.rs2;
    assign d  = instruction.r.rd;

    // Format from the opcode, reserved funct3 codes fall back to NOP
    always_comb begin
        case (instruction.r.opcode)
            OP_LUI, OP_AUIPC: mFmt = fmtU;
            OP_JAL:           mFmt = fmtJ;
            OP_JALR, OP_IMM:  mFmt = fmtI;
            OP_REG:           mFmt = fmtR;
            OP_LOAD:   mFmt = (instruction.i.funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ?
                              fmtI : fmtNop;
            OP_STORE:  mFmt = (instruction.sb.funct3 < 3'd3) ? fmtS : fmtNop;
            OP_BRANCH: mFmt = (instruction.sb.funct3 inside {3'd2, 3'd3}) ? fmtNop : fmtB;
            default:   mFmt = fmtNop;
        endcase
    end

    assign useRs1 = mFmt inside {fmtR, fmtI, fmtS, fmtB};
    assign useRs2 = mFmt inside {fmtR, fmtS, fmtB};
    assign useRd  = mFmt inside {fmtR, fmtI, fmtU, fmtJ};
    assign load   = (instruction.r.opcode == OP_LOAD) && (mFmt == fmtI);
    assign store  = (mFmt == fmtS);

    // Immediates rebuilt from the raw bit positions of the ISA manual
    always_comb begin
        case (mFmt)
            fmtI:    mImm = {{20{instruction.raw[31]}}, instruction.i.imm12};
            fmtS:    mImm = {{20{instruction.raw[31]}}, instruction.raw[31:25],
                             instruction.raw[11:7]};
            fmtB:    mImm = {{20{instruction.raw[31]}}, instruction.raw[7],
                             instruction.raw[30:25], instruction.raw[11:8], 1'b0};
            fmtU:    mImm = {instruction.raw[31:12], 12'h000};
            fmtJ:    mImm = {{12{instruction.raw[31]}}, instruction.raw[19:12],
                             instruction.raw[20], instruction.raw[30:21], 1'b0};
            default: mImm = '0;
        endcase
    end

    always_comb begin
        regA = useRs1 ? shadow[s1] : '0;                // shadow[0] stays zero
        regB = useRs2 ? shadow[s2] : '0;
        case (mFmt)
            fmtI:       {rA, rB, rC} = {regA, mImm, `XLEN'(0)};
            fmtU, fmtJ: {rA, rB, rC} = {npc, mImm, `XLEN'(0)};
            fmtS:       {rA, rB, rC} = {regA, mImm, regB};
            fmtR, fmtB: {rA, rB, rC} = {regA, regB, mImm};
            default:    {rA, rB, rC} = {mImm, `XLEN'(0), `XLEN'(0)};
        endcase
    end

    always_comb begin
        mLocked = '0;
        for (int e = 0; e < `LOCK_DEPTH; e++) begin
            mLocked |= mQueue[e];
        end
        pushMask    = '0;
        pushMask[d] = useRd;
        pushMask[0] = store;                            // Store marker, also hides rd of x0
    end

    assign mIssue = !((useRs1 && s1 != '0 && mLocked[s1]) ||
                      (useRs2 && s2 != '0 && mLocked[s2]) || (load && mLocked[0]));

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int e = 0; e < `LOCK_DEPTH; e++) begin
                mQueue[e] <= '0;
            end
            {eA, eB, eC, eNpc, eTag} <= '0;
            eBubble <= 1'b1;
        end else begin
            for (int e = `LOCK_DEPTH - 1; e > 0; e--) begin
                mQueue[e] <= mQueue[e-1];
            end
            mQueue[0] <= mIssue ? pushMask : '0;
            eBubble   <= !mIssue;
            {eA, eB, eC, eNpc, eTag} <= mIssue ? {rA, rB, rC, npc, tagIn} : '0;
        end
    end

    aIssue: assert property (@(posedge clk) disable iff (!reset) issue == mIssue)
        else begin
            controlErrs++;
            $display("ERR %0t: issue %b, expected %b", $time, $sampled(issue), $sampled(mIssue));
        end

    aRetire: assert property (@(posedge clk) disable iff (!reset)
        wrAddr == (mQueue[`LOCK_DEPTH-1][`NREGS-1:1] & {(`NREGS-1){wbEn}}))
        else begin
            controlErrs++;
            $display("ERR %0t: wrAddr %h, expected %h", $time, $sampled(wrAddr),
                     $sampled(mQueue[`LOCK_DEPTH-1][`NREGS-1:1]));
        end

    aOperands: assert property (@(posedge clk) disable iff (!reset)
        {opA, opB, opC} == {eA, eB, eC})
        else begin
            operandErrs++;
            $display("ERR %0t: operands %h %h %h, expected %h %h %h", $time, $sampled(opA),
                     $sampled(opB), $sampled(opC), $sampled(eA), $sampled(eB), $sampled(eC));
        end

    aCtrlOut: assert property (@(posedge clk) disable iff (!reset)
        npcOut == eNpc && tagOut == eTag && (!eBubble || (opOut == OP0 && xuOut == xuBypass)))
        else begin
            controlErrs++;
            $display("ERR %0t: npcOut %h tagOut %h, expected %h %h bubble %b", $time,
                     $sampled(npcOut), $sampled(tagOut), $sampled(eNpc), $sampled(eTag),
                     $sampled(eBubble));
        end

endmodule

// ==== frontEnd.sv ====
// Front end top joining the RV32I decoder, operand fetch stage and register bank
`include "frontEnd_macros.svh"

module frontEnd (
    input  logic                clk,
    input  logic                reset,
    input  rvIsaPkg::instrWord  instruction,  // Held while issue is low
    input  logic [`XLEN-1:0]    npc,
    input  logic [`TAG_W-1:0]   tagIn,
    input  logic                wbEn,         // Write-back from execute
    input  logic [`XLEN-1:0]    wbData,
    output logic [`XLEN-1:0]    opA,
    output logic [`XLEN-1:0]    opB,
    output logic [`XLEN-1:0]    opC,
    output logic [`XLEN-1:0]    npcOut,
    output pipeCtrlPkg::opCode  opOut,
    output pipeCtrlPkg::xuSel   xuOut,
    output logic [`TAG_W-1:0]   tagOut,
    output logic                issue,
    output logic [`NREGS-1:1]   wrAddr        // Lets execute align its write-back
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    instrFmt          fmt;
    xuSel             xu;
    opCode            op;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [4:0]       rdAddrA;
    logic [4:0]       rdAddrB;
    logic [`XLEN-1:0] rdDataA;
    logic [`XLEN-1:0] rdDataB;

    instrDecode decode (
        .instruction, .fmt, .xu, .op, .rs1, .rs2, .rd
    );

    operandFetch #(.DEPTH(`LOCK_DEPTH)) fetch (
        .clk, .reset, .wbEn, .fmt, .xu, .op, .rs1, .rs2, .rd,
        .instruction, .npc, .tagIn, .rdDataA, .rdDataB,
        .rdAddrA, .rdAddrB, .wrAddr,
        .opA, .opB, .opC, .npcOut, .opOut, .xuOut, .tagOut, .issue
    );

    regBank bank (
        .clk, .reset, .rdAddrA, .rdAddrB, .wrAddr, .wbData, .rdDataA, .rdDataB
    );

endmodule

// ==== regBank.sv ====
// Register bank with hard zero, two combinational read ports and a one-hot write port
`include "frontEnd_macros.svh"

module regBank (
    input  logic              clk,
    input  logic              reset,
    input  logic [4:0]        rdAddrA,
    input  logic [4:0]        rdAddrB,
    input  logic [`NREGS-1:1] wrAddr,      // One-hot, already gated by wbEn
    input  logic [`XLEN-1:0]  wbData,
    output logic [`XLEN-1:0]  rdDataA,
    output logic [`XLEN-1:0]  rdDataB
);
    logic [`XLEN-1:0] regs [1:`NREGS-1];   // x0 has no storage

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 1; r < `NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int r = 1; r < `NREGS; r++) begin
                if (wrAddr[r]) begin
                    regs[r] <= wbData;     // Every set bit takes the data
                end
            end
        end
    end

    // No write-to-read bypass, the stall spans the write cycle
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

    aWrOneHot: assert property (@(posedge clk) disable iff (!reset) $onehot0(wrAddr))
        else $error("Register bank write address is not one-hot");

endmodule

// ==== operandFetch.sv ====
// Operand fetch with immediate build, operand routing, register lock queue and issue registers
`include "frontEnd_macros.svh"

module operandFetch #(
    parameter int DEPTH = `LOCK_DEPTH              // Cycles from issue to retirement (1 or more)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                wbEn,               // Write-back valid from execute
    input  rvIsaPkg::instrFmt   fmt,
    input  pipeCtrlPkg::xuSel   xu,
    input  pipeCtrlPkg::opCode  op,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  rvIsaPkg::instrWord  instruction,        // Immediate source
    input  logic [`XLEN-1:0]    npc,
    input  logic [`TAG_W-1:0]   tagIn,
    input  logic [`XLEN-1:0]    rdDataA,            // Bank read in the same cycle
    input  logic [`XLEN-1:0]    rdDataB,
    output logic [4:0]          rdAddrA,
    output logic [4:0]          rdAddrB,
    output logic [`NREGS-1:1]   wrAddr,             // One-hot retiring destination
    output logic [`XLEN-1:0]    opA,
    output logic [`XLEN-1:0]    opB,
    output logic [`XLEN-1:0]    opC,
    output logic [`XLEN-1:0]    npcOut,
    output pipeCtrlPkg::opCode  opOut,
    output pipeCtrlPkg::xuSel   xuOut,
    output logic [`TAG_W-1:0]   tagOut,
    output logic                issue               // Low holds fetch and sends a bubble
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [`XLEN-1:0]  imm;
    logic [`XLEN-1:0]  routeA;
    logic [`XLEN-1:0]  routeB;
    logic [`XLEN-1:0]  routeC;
    logic [`NREGS-1:0] rdOneHot;
    logic [`NREGS-1:0] target;                      // Entry pushed this cycle
    logic [`NREGS-1:0] locked;                      // OR of all pending writes
    logic [`NREGS-1:0] lockQueue [DEPTH];
    logic              hazardA;
    logic              hazardB;
    logic              storeHazard;

    // Sign-extended immediate per format
    always_comb begin
        case (fmt)
            fmtI: imm = {{20{instruction.i.imm12[11]}}, instruction.i.imm12};
            fmtS: imm = {{20{instruction.sb.immHi[6]}}, instruction.sb.immHi,
                         instruction.sb.immLo};
            fmtB: imm = {{19{instruction.sb.immHi[6]}}, instruction.sb.immHi[6],
                         instruction.sb.immLo[0], instruction.sb.immHi[5:0],
                         instruction.sb.immLo[4:1], 1'b0};
            fmtU: imm = {instruction.uj.imm20, 12'b0};
            fmtJ: imm = {{11{instruction.uj.imm20[19]}}, instruction.uj.imm20[19],
                         instruction.uj.imm20[7:0], instruction.uj.imm20[8],
                         instruction.uj.imm20[18:9], 1'b0};
            default: imm = '0;                      // NOP carries no immediate
        endcase
    end

    assign rdAddrA = rs1;
    assign rdAddrB = rs2;

    // Operand routing toward execute
    always_comb begin
        routeA = rdDataA;
        routeB = imm;
        routeC = '0;
        case (fmt)
            fmtI: ;                                 // ALU immediates, loads, JALR
            fmtU, fmtJ: routeA = npc;               // AUIPC, LUI, JAL
            fmtS: routeC = rdDataB;                 // Store data in C
            fmtR, fmtB: begin
                routeB = rdDataB;
                routeC = imm;                       // Branch offset in C
            end
            default: begin
                routeA = imm;
                routeB = '0;
            end
        endcase
    end

    // Bit 0 marks a pending store and register 0 never locks
    assign rdOneHot = `NREGS'(1) << rd;
    assign target   = issue ? {rdOneHot[`NREGS-1:1], isStore(xu, op)} : '0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int e = 0; e < DEPTH; e++) begin
                lockQueue[e] <= '0;
            end
        end else begin
            for (int e = DEPTH - 1; e > 0; e--) begin
                lockQueue[e] <= lockQueue[e-1];      // Shift toward the tail
            end
            lockQueue[0] <= target;
        end
    end

    always_comb begin
        locked = '0;
        for (int e = 0; e < DEPTH; e++) begin
            locked |= lockQueue[e];
        end
    end

    assign wrAddr = lockQueue[DEPTH-1][`NREGS-1:1] & {(`NREGS-1){wbEn}};

    // Read-after-write and load-after-store hazards
    assign hazardA     = (rs1 != '0) && locked[rs1];
    assign hazardB     = (rs2 != '0) && locked[rs2];
    assign storeHazard = isLoad(xu, op) && locked[0];
    assign issue       = !(hazardA || hazardB || storeHazard);

    // Issue registers load a bubble when stalled
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            opA    <= '0;
            opB    <= '0;
            opC    <= '0;
            npcOut <= '0;
            opOut  <= OP0;
            xuOut  <= xuBypass;
            tagOut <= '0;
        end else if (!issue) begin
            opA    <= '0;
            opB    <= '0;
            opC    <= '0;
            npcOut <= '0;
            opOut  <= OP0;
            xuOut  <= xuBypass;
            tagOut <= '0;
        end else begin
            opA    <= routeA;
            opB    <= routeB;
            opC    <= routeC;
            npcOut <= npc;
            opOut  <= op;
            xuOut  <= xu;
            tagOut <= tagIn;
        end
    end

    for (genvar e = 0; e < DEPTH; e++) begin : gEntryCheck
        aEntryOneHot: assert property (@(posedge clk) disable iff (!reset)
            $onehot0(lockQueue[e][`NREGS-1:1]))
            else $error("Lock queue entry %0d holds more than one register", e);
    end

    aWrAddrOneHot: assert property (@(posedge clk) disable iff (!reset) $onehot0(wrAddr))
        else $error("Retiring write address has several bits set");

    property bubbleAfterStall;
        @(posedge clk) disable iff (!reset)
        !issue |=> (opA == '0 && opB == '0 && opC == '0 && npcOut == '0 &&
                    opOut == OP0 && xuOut == xuBypass && tagOut == '0);
    endproperty
    aBubbleAfterStall: assert property (bubbleAfterStall)
        else $error("Outputs left the bubble values after a stall");

endmodule

// ==== instrDecode.sv ====
// RV32I decoder giving format, execute unit, operation and used register fields
module instrDecode (
    input  rvIsaPkg::instrWord instruction, // Held instruction word
    output rvIsaPkg::instrFmt  fmt,         // Encoding format
    output pipeCtrlPkg::xuSel  xu,          // Target execute unit
    output pipeCtrlPkg::opCode op,          // Operation inside that unit
    output logic [4:0]         rs1,         // Zero when the format has no rs1
    output logic [4:0]         rs2,         // Zero when the format has no rs2
    output logic [4:0]         rd           // Zero when the format has no rd
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [2:0] funct3;
    logic       alt;                         // Instruction bit 30
    logic       isRegOp;
    xuSel       aluXu;
    opCode      aluOp;

    assign funct3  = instruction.r.funct3;
    assign alt     = instruction.r.funct7[5];
    assign isRegOp = (instruction.r.opcode == OP_REG);

    // ALU class shared by OP-IMM and OP
    always_comb begin
        aluXu = xuAdder;
        aluOp = OP0;
        case (funct3)
            3'b000: aluOp = (isRegOp && alt) ? OP1 : OP0;   // ADD or SUB, no SUBI
            3'b010: aluOp = OP2;                            // SLT
            3'b011: aluOp = OP3;                            // SLTU
            3'b100: aluXu = xuLogic;                        // XOR as OP0
            3'b110: begin
                aluXu = xuLogic;
                aluOp = OP1;                                // OR
            end
            3'b111: begin
                aluXu = xuLogic;
                aluOp = OP2;                                // AND
            end
            3'b001: aluXu = xuShifter;                      // SLL as OP0
            default: begin
                aluXu = xuShifter;
                aluOp = alt ? OP2 : OP1;                    // SRA or SRL
            end
        endcase
    end

    always_comb begin
        fmt = fmtNop;                                       // Unknown opcode stays a NOP
        xu  = xuBypass;
        op  = OP0;
        case (instruction.r.opcode)
            OP_LUI: begin
                fmt = fmtU;
                xu  = xuAdder;
                op  = OP4;                                  // Pass immediate through
            end
            OP_AUIPC: begin
                fmt = fmtU;
                xu  = xuAdder;                              // npc plus immediate
            end
            OP_JAL: begin
                fmt = fmtJ;
                xu  = xuBranch;
                op  = OP6;
            end
            OP_JALR: begin
                fmt = fmtI;
                xu  = xuBranch;
                op  = OP7;
            end
            OP_BRANCH: if (funct3[2:1] != 2'b01) begin      // 010 and 011 are reserved
                fmt = fmtB;
                xu  = xuBranch;
                op  = funct3[2] ? opCode'(funct3 - 3'd2) : opCode'(funct3);
            end
            OP_LOAD: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                fmt = fmtI;
                xu  = xuMemory;
                op  = funct3[2] ? opCode'(funct3 - 3'd1) : opCode'(funct3); // LBU, LHU to OP3, OP4
            end
            OP_STORE: if (funct3 < 3'd3) begin
                fmt = fmtS;
                xu  = xuMemory;
                op  = opCode'(funct3 + 3'd5);               // SB SH SW
            end
            OP_IMM: begin
                fmt = fmtI;
                xu  = aluXu;
                op  = aluOp;
            end
            OP_REG: begin
                fmt = fmtR;
                xu  = aluXu;
                op  = aluOp;
            end
            default: ;
        endcase
    end

    // Unused fields forced to zero so they never lock
    always_comb begin
        rs1 = '0;
        rs2 = '0;
        rd  = '0;
        case (fmt)
            fmtR: begin
                rs1 = instruction.r.rs1;
                rs2 = instruction.r.rs2;
                rd  = instruction.r.rd;
            end
            fmtI: begin
                rs1 = instruction.i.rs1;
                rd  = instruction.i.rd;
            end
            fmtS, fmtB: begin
                rs1 = instruction.sb.rs1;
                rs2 = instruction.sb.rs2;
            end
            fmtU, fmtJ: rd = instruction.uj.rd;
            default: ;
        endcase
    end

endmodule

// ==== pipeCtrlPkg.sv ====
// Pipeline control package with execute unit selection and per-unit operation codes
package pipeCtrlPkg;

    typedef enum logic [2:0] {
        xuAdder   = 3'd0,       // ADD, SUB, SLT, SLTU, AUIPC, LUI
        xuLogic   = 3'd1,       // XOR, OR, AND
        xuShifter = 3'd2,       // SLL, SRL, SRA
        xuBranch  = 3'd3,       // Conditional branches and jumps
        xuMemory  = 3'd4,       // Loads and stores
        xuBypass  = 3'd5        // Bubble or unknown instruction
    } xuSel;

    // Memory unit uses OP0..OP4 for LB LH LW LBU LHU and OP5..OP7 for SB SH SW
    typedef enum logic [2:0] {
        OP0, OP1, OP2, OP3, OP4, OP5, OP6, OP7
    } opCode;

    function automatic logic isLoad(xuSel xu, opCode op);
        return (xu == xuMemory) && (op inside {OP0, OP1, OP2, OP3, OP4});
    endfunction

    function automatic logic isStore(xuSel xu, opCode op);
        return (xu == xuMemory) && (op inside {OP5, OP6, OP7});
    endfunction

endpackage

// ==== rvIsaPkg.sv ====
// RV32I encoding package with instruction formats, major opcodes and field views of one word
package rvIsaPkg;

    typedef enum logic [2:0] {
        fmtR   = 3'd0,          // Register-register
        fmtI   = 3'd1,          // Immediate, loads, JALR
        fmtS   = 3'd2,          // Stores
        fmtB   = 3'd3,          // Conditional branches
        fmtU   = 3'd4,          // LUI, AUIPC
        fmtJ   = 3'd5,          // JAL
        fmtNop = 3'd6           // Unknown or empty slot
    } instrFmt;

    // Major opcodes, bits 6:0
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef struct packed {
        logic [6:0] funct7;     // Bit 5 picks SUB and SRA
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields;

    typedef struct packed {
        logic [11:0] imm12;     // Sign in bit 11
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFields;

    typedef struct packed {
        logic [6:0] immHi;      // imm[11:5], B keeps imm[12] and imm[10:5] here
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;      // imm[4:0], B keeps imm[4:1] and imm[11] here
        logic [6:0] opcode;
    } sbFields;

    typedef struct packed {
        logic [19:0] imm20;     // U upper bits or scrambled J offset
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } ujFields;

    // Same 32 bits seen through each format
    typedef union packed {
        logic [31:0] raw;
        rFields      r;
        iFields      i;
        sbFields     sb;
        ujFields     uj;
    } instrWord;

endpackage

// ==== frontEnd_macros.svh ====
// Front end global widths and depths for decode, operand fetch and register bank
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Datapath
`define XLEN 32        // Data word width
`define NREGS 32       // Register count including the hard zero

// Pipeline control
`define LOCK_DEPTH 2   // Cycles from issue to write retirement
`define TAG_W 4        // Instruction tag width

`endif
